// File: rvvi_defines.svh
`ifndef RVVI_DEFINES_SVH
`define RVVI_DEFINES_SVH

// Data and trace field widths
`define XLEN              32
`define ORDER_W           64
`define IRQ_W             32
`define CSR_ADDR_W        12

// Tracked CSRs
`define CSR_SLOTS         8

// Event queue sizing and initial consumer credits
`define EVENT_DEPTH       8
`define EVENT_CREDITS     4

// Special causes seen on the retirement trace
`define CAUSE_FETCH_FAULT 48
`define CAUSE_NMI_LOAD    1024
`define CAUSE_NMI_STORE   1025
`define DBG_HALTREQ       3

`endif

// File: rvfi_trace_pkg.sv
`include "rvvi_defines.svh"

package rvfi_trace_pkg;

   typedef logic [`XLEN-1:0]       xlen_t;
   typedef logic [`ORDER_W-1:0]    order_t;
   typedef logic [4:0]             reg_idx_t;
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [2:0]             csr_slot_t;
   typedef logic [5:0]             exc_cause_t;
   typedef logic [10:0]            intr_cause_t;
   typedef logic [31:0]            gpr_mask_t;

   // mstatus, mie, mtvec, mscratch, mepc, mcause, mtval, dcsr
   localparam csr_addr_t csr_slot_addr [`CSR_SLOTS] = '{
      12'h300, 12'h304, 12'h305, 12'h340,
      12'h341, 12'h342, 12'h343, 12'h7B0
   };

endpackage

// File: rvvi_net_pkg.sv
`include "rvvi_defines.svh"

package rvvi_net_pkg;

   // Lower ids win when several nets are pending
   typedef enum logic [4:0] {
      net_nmi, net_nmi_cause, net_ifault, net_haltreq,
      net_irq_0, net_irq_1, net_irq_2, net_irq_3,
      net_irq_4, net_irq_5, net_irq_6, net_irq_7,
      net_irq_8, net_irq_9, net_irq_10, net_irq_11,
      net_irq_12, net_irq_13, net_irq_14, net_irq_15,
      net_irq_16, net_irq_17, net_irq_18
   } net_id_t;

   typedef logic [`XLEN-1:0] net_value_t;

   localparam int NET_COUNT = 23;
   localparam int IRQ_LINES = 19;

   // Software, timer, external, then the 16 local lines
   localparam int irq_line_idx [IRQ_LINES] = '{
      3, 7, 11,
      16, 17, 18, 19, 20, 21, 22, 23,
      24, 25, 26, 27, 28, 29, 30, 31
   };

endpackage

// File: retire_if.sv
interface retire_if;
   import rvfi_trace_pkg::*;

   logic        valid;
   order_t      order;
   xlen_t       pc_rdata;
   xlen_t       pc_wdata;
   xlen_t       insn;
   reg_idx_t    rd_addr;
   xlen_t       rd_wdata;
   logic        csr_hit;
   csr_slot_t   csr_slot;
   xlen_t       csr_rdata;
   xlen_t       csr_wdata;
   xlen_t       csr_wmask;
   logic        fetch_fault;
   logic        nmi_req;
   intr_cause_t nmi_cause;
   logic        halt_req;

   modport decode (
      output valid, order, pc_rdata, pc_wdata, insn, rd_addr, rd_wdata,
             csr_hit, csr_slot, csr_rdata, csr_wdata, csr_wmask,
             fetch_fault, nmi_req, nmi_cause, halt_req
   );

   modport consumer (
      input valid, order, pc_rdata, pc_wdata, insn, rd_addr, rd_wdata,
            csr_hit, csr_slot, csr_rdata, csr_wdata, csr_wmask,
            fetch_fault, nmi_req, nmi_cause, halt_req
   );
endinterface

// File: net_event_if.sv
interface net_event_if;
   import rvvi_net_pkg::*;

   logic       valid;
   net_id_t    id;
   net_value_t value;
   // Queue cannot take an entry this cycle
   logic       full;

   modport source (output valid, id, value, input full);
   modport sink (input valid, id, value, output full);
endinterface

// File: retire_decode.sv
`include "rvvi_defines.svh"

module retire_decode (
   input  logic                       rvvi,
   input  logic                       reset,
   input  logic                       rvfi_valid,
   input  rvfi_trace_pkg::order_t      rvfi_order,
   input  rvfi_trace_pkg::xlen_t       rvfi_insn,
   input  rvfi_trace_pkg::xlen_t       rvfi_pc_rdata,
   input  rvfi_trace_pkg::xlen_t       rvfi_pc_wdata,
   input  logic                       rvfi_trap,
   input  logic                       rvfi_trap_exception,
   input  rvfi_trace_pkg::exc_cause_t  rvfi_exc_cause,
   input  logic                       rvfi_intr,
   input  logic                       rvfi_intr_interrupt,
   input  rvfi_trace_pkg::intr_cause_t rvfi_intr_cause,
   input  logic [1:0]                 rvfi_nmip,
   input  logic [2:0]                 rvfi_dbg,
   input  logic                       rvfi_dbg_mode,
   input  rvfi_trace_pkg::reg_idx_t    rvfi_rd_addr,
   input  rvfi_trace_pkg::xlen_t       rvfi_rd_wdata,
   input  rvfi_trace_pkg::csr_addr_t   rvfi_csr_addr,
   input  rvfi_trace_pkg::xlen_t       rvfi_csr_rdata,
   input  rvfi_trace_pkg::xlen_t       rvfi_csr_wdata,
   input  rvfi_trace_pkg::xlen_t       rvfi_csr_wmask,
   retire_if.decode                   ret
);
   import rvfi_trace_pkg::*;

   order_t      last_order;
   logic        order_seen;
   logic        accept;
   logic        nmi_by_intr;
   intr_cause_t nmi_cause_d;
   logic        csr_hit_d;
   csr_slot_t   csr_slot_d;

   // First record after reset takes any order
   assign accept = rvfi_valid && (!order_seen || rvfi_order != last_order);

   assign nmi_by_intr = rvfi_intr && rvfi_intr_interrupt &&
                        (rvfi_intr_cause == intr_cause_t'(`CAUSE_NMI_LOAD) ||
                         rvfi_intr_cause == intr_cause_t'(`CAUSE_NMI_STORE));

   // Pending NMI without a taken cause takes its kind from nmip[1]
   assign nmi_cause_d = nmi_by_intr ? rvfi_intr_cause :
                        rvfi_nmip[1] ? intr_cause_t'(`CAUSE_NMI_STORE) :
                                       intr_cause_t'(`CAUSE_NMI_LOAD);

   always_comb begin
      csr_hit_d  = 1'b0;
      csr_slot_d = '0;
      for (int i = 0; i < `CSR_SLOTS; i++) begin
         if (rvfi_csr_addr == csr_slot_addr[i]) begin
            csr_hit_d  = 1'b1;
            csr_slot_d = csr_slot_t'(i);
         end
      end
   end

   always_ff @(posedge rvvi) begin
      if (reset) begin
         order_seen <= 1'b0;
         last_order <= '0;
         ret.valid  <= 1'b0;
      end else begin
         ret.valid <= accept;
         if (accept) begin
            order_seen <= 1'b1;
            last_order <= rvfi_order;
         end
      end
   end

   ////////////////////
   // Record payload
   ////////////////////
   always_ff @(posedge rvvi) begin
      if (accept) begin
         ret.order       <= rvfi_order;
         ret.pc_rdata    <= rvfi_pc_rdata;
         ret.pc_wdata    <= rvfi_pc_wdata;
         ret.insn        <= rvfi_insn;
         ret.rd_addr     <= rvfi_rd_addr;
         ret.rd_wdata    <= rvfi_rd_wdata;
         ret.csr_hit     <= csr_hit_d;
         ret.csr_slot    <= csr_slot_d;
         ret.csr_rdata   <= rvfi_csr_rdata;
         ret.csr_wdata   <= rvfi_csr_wdata;
         ret.csr_wmask   <= rvfi_csr_wmask;
         ret.fetch_fault <= rvfi_trap && rvfi_trap_exception &&
                            rvfi_exc_cause == exc_cause_t'(`CAUSE_FETCH_FAULT);
         ret.nmi_req     <= nmi_by_intr || rvfi_nmip[0];
         ret.nmi_cause   <= nmi_cause_d;
         ret.halt_req    <= rvfi_dbg_mode && rvfi_dbg == 3'(`DBG_HALTREQ);
      end
   end

endmodule

// File: csr_gpr_shadow.sv
`include "rvvi_defines.svh"

module csr_gpr_shadow (
   input  logic                     rvvi,
   input  logic                     reset,
   retire_if.consumer               ret,
   output logic                     trace_valid,
   output rvfi_trace_pkg::order_t    trace_order,
   output rvfi_trace_pkg::xlen_t     trace_pc,
   output rvfi_trace_pkg::xlen_t     trace_insn,
   output rvfi_trace_pkg::gpr_mask_t trace_gpr_mask,
   output rvfi_trace_pkg::xlen_t     trace_rd_wdata,
   output rvfi_trace_pkg::csr_slot_t trace_csr_slot,
   output rvfi_trace_pkg::xlen_t     trace_csr_value,
   output logic                     trace_csr_changed
);
   import rvfi_trace_pkg::*;

   xlen_t    csr_shadow [`CSR_SLOTS];
   xlen_t    gpr_shadow [1:31];
   xlen_t    csr_merged;
   reg_idx_t rd_q;

   // Written bits from wdata, the rest as read
   assign csr_merged = (ret.csr_wdata & ret.csr_wmask) | (ret.csr_rdata & ~ret.csr_wmask);

   ////////////////////
   // Shadow state
   ////////////////////
   always_ff @(posedge rvvi) begin
      if (reset) begin
         trace_valid <= 1'b0;
         for (int i = 0; i < `CSR_SLOTS; i++) begin
            csr_shadow[i] <= '0;
         end
         for (int r = 1; r < 32; r++) begin
            gpr_shadow[r] <= '0;
         end
      end else begin
         trace_valid <= ret.valid;
         if (ret.valid && ret.csr_hit) begin
            csr_shadow[ret.csr_slot] <= csr_merged;
         end
         // x0 stays hardwired to zero
         if (ret.valid && ret.rd_addr != '0) begin
            gpr_shadow[ret.rd_addr] <= ret.rd_wdata;
         end
      end
   end

   always_ff @(posedge rvvi) begin
      if (ret.valid) begin
         trace_order       <= ret.order;
         // A faulted fetch executes nothing, so the handler address is reported
         trace_pc          <= ret.fetch_fault ? ret.pc_wdata : ret.pc_rdata;
         trace_insn        <= ret.insn;
         rd_q              <= ret.rd_addr;
         trace_csr_slot    <= ret.csr_slot;
         trace_csr_value   <= ret.csr_hit ? csr_merged : '0;
         trace_csr_changed <= ret.csr_hit && (csr_merged != csr_shadow[ret.csr_slot]);
      end
   end

   // Write-back view read back from the shadow
   assign trace_gpr_mask = (rd_q == '0) ? '0 : gpr_mask_t'(1) << rd_q;
   assign trace_rd_wdata = (rd_q == '0) ? '0 : gpr_shadow[rd_q];

endmodule

// File: net_tracker.sv
`include "rvvi_defines.svh"

module net_tracker (
   input  logic             rvvi,
   input  logic             reset,
   input  logic [`IRQ_W-1:0] irq,
   retire_if.consumer       ret,
   net_event_if.source      ev
);
   import rvvi_net_pkg::*;

   net_value_t           level_q [NET_COUNT];
   net_value_t           level_d [NET_COUNT];
   logic [NET_COUNT-1:0] pending_q;
   logic [NET_COUNT-1:0] changed;
   logic [NET_COUNT-1:0] sent;
   logic                 pick_valid;
   logic [4:0]           pick;

   ////////////////////
   // Next levels
   ////////////////////
   always_comb begin
      level_d = level_q;
      if (ret.valid) begin
         level_d[net_nmi]    = net_value_t'(ret.nmi_req);
         // Cause holds its last value once the NMI drops
         if (ret.nmi_req) begin
            level_d[net_nmi_cause] = net_value_t'(ret.nmi_cause);
         end
         level_d[net_ifault]  = net_value_t'(ret.fetch_fault);
         level_d[net_haltreq] = net_value_t'(ret.halt_req);
      end
      for (int i = 0; i < IRQ_LINES; i++) begin
         level_d[int'(net_irq_0) + i] = net_value_t'(irq[irq_line_idx[i]]);
      end
      for (int n = 0; n < NET_COUNT; n++) begin
         changed[n] = level_d[n] != level_q[n];
      end
   end

   // Lowest pending id
   always_comb begin
      pick_valid = 1'b0;
      pick       = '0;
      for (int n = NET_COUNT - 1; n >= 0; n--) begin
         if (pending_q[n]) begin
            pick_valid = 1'b1;
            pick       = 5'(n);
         end
      end
   end

   assign ev.valid = pick_valid && !ev.full;
   assign ev.id    = net_id_t'(pick);
   assign ev.value = level_q[pick];

   assign sent = ev.valid ? NET_COUNT'(1) << pick : '0;

   always_ff @(posedge rvvi) begin
      if (reset) begin
         pending_q <= '0;
         for (int n = 0; n < NET_COUNT; n++) begin
            level_q[n] <= '0;
         end
      end else begin
         // A fresh change re-arms a net even as it goes out
         pending_q <= (pending_q & ~sent) | changed;
         level_q   <= level_d;
      end
   end

endmodule

// File: net_event_queue.sv
`include "rvvi_defines.svh"

module net_event_queue (
   input  logic                     rvvi,
   input  logic                     reset,
   net_event_if.sink                ev,
   input  logic                     event_credit,
   output logic                     event_valid,
   output rvvi_net_pkg::net_id_t     event_id,
   output rvvi_net_pkg::net_value_t  event_value
);
   import rvvi_net_pkg::*;

   localparam int PTR_W    = $clog2(`EVENT_DEPTH);
   localparam int CREDIT_W = $clog2(`EVENT_CREDITS + 1);

   net_id_t             id_mem  [`EVENT_DEPTH];
   net_value_t          val_mem [`EVENT_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [PTR_W:0]      count;
   logic [CREDIT_W-1:0] credits;
   logic                push;

   assign ev.full = count == (PTR_W + 1)'(`EVENT_DEPTH);
   assign push    = ev.valid && !ev.full;

   // Every cycle shown is a pop and uses one credit
   assign event_valid = (count != '0) && (credits != '0);
   assign event_id    = id_mem[rd_ptr];
   assign event_value = val_mem[rd_ptr];

   always_ff @(posedge rvvi) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= CREDIT_W'(`EVENT_CREDITS);
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
         end
         if (event_valid) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
         count   <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(event_valid);
         credits <= credits - CREDIT_W'(event_valid) + CREDIT_W'(event_credit);
      end
   end

   ////////////////////
   // Storage
   ////////////////////
   always_ff @(posedge rvvi) begin
      if (push) begin
         id_mem[wr_ptr]  <= ev.id;
         val_mem[wr_ptr] <= ev.value;
      end
   end

endmodule

// File: rvvi_bridge.sv
`include "rvvi_defines.svh"

module rvvi_bridge (
   input  logic                       rvvi,
   input  logic                       reset,
   input  logic                       rvfi_valid,
   input  rvfi_trace_pkg::order_t      rvfi_order,
   input  rvfi_trace_pkg::xlen_t       rvfi_insn,
   input  rvfi_trace_pkg::xlen_t       rvfi_pc_rdata,
   input  rvfi_trace_pkg::xlen_t       rvfi_pc_wdata,
   input  logic                       rvfi_trap,
   input  logic                       rvfi_trap_exception,
   input  rvfi_trace_pkg::exc_cause_t  rvfi_exc_cause,
   input  logic                       rvfi_intr,
   input  logic                       rvfi_intr_interrupt,
   input  rvfi_trace_pkg::intr_cause_t rvfi_intr_cause,
   input  logic [1:0]                 rvfi_nmip,
   input  logic [2:0]                 rvfi_dbg,
   input  logic                       rvfi_dbg_mode,
   input  rvfi_trace_pkg::reg_idx_t    rvfi_rd_addr,
   input  rvfi_trace_pkg::xlen_t       rvfi_rd_wdata,
   input  rvfi_trace_pkg::csr_addr_t   rvfi_csr_addr,
   input  rvfi_trace_pkg::xlen_t       rvfi_csr_rdata,
   input  rvfi_trace_pkg::xlen_t       rvfi_csr_wdata,
   input  rvfi_trace_pkg::xlen_t       rvfi_csr_wmask,
   input  logic [`IRQ_W-1:0]          irq,
   input  logic                       event_credit,
   output logic                       trace_valid,
   output rvfi_trace_pkg::order_t      trace_order,
   output rvfi_trace_pkg::xlen_t       trace_pc,
   output rvfi_trace_pkg::xlen_t       trace_insn,
   output rvfi_trace_pkg::gpr_mask_t   trace_gpr_mask,
   output rvfi_trace_pkg::xlen_t       trace_rd_wdata,
   output rvfi_trace_pkg::csr_slot_t   trace_csr_slot,
   output rvfi_trace_pkg::xlen_t       trace_csr_value,
   output logic                       trace_csr_changed,
   output logic                       event_valid,
   output rvvi_net_pkg::net_id_t       event_id,
   output rvvi_net_pkg::net_value_t    event_value
);

   retire_if    ret ();
   net_event_if ev ();

   retire_decode u_decode (
      .rvvi                (rvvi),
      .reset               (reset),
      .rvfi_valid          (rvfi_valid),
      .rvfi_order          (rvfi_order),
      .rvfi_insn           (rvfi_insn),
      .rvfi_pc_rdata       (rvfi_pc_rdata),
      .rvfi_pc_wdata       (rvfi_pc_wdata),
      .rvfi_trap           (rvfi_trap),
      .rvfi_trap_exception (rvfi_trap_exception),
      .rvfi_exc_cause      (rvfi_exc_cause),
      .rvfi_intr           (rvfi_intr),
      .rvfi_intr_interrupt (rvfi_intr_interrupt),
      .rvfi_intr_cause     (rvfi_intr_cause),
      .rvfi_nmip           (rvfi_nmip),
      .rvfi_dbg            (rvfi_dbg),
      .rvfi_dbg_mode       (rvfi_dbg_mode),
      .rvfi_rd_addr        (rvfi_rd_addr),
      .rvfi_rd_wdata       (rvfi_rd_wdata),
      .rvfi_csr_addr       (rvfi_csr_addr),
      .rvfi_csr_rdata      (rvfi_csr_rdata),
      .rvfi_csr_wdata      (rvfi_csr_wdata),
      .rvfi_csr_wmask      (rvfi_csr_wmask),
      .ret                 (ret.decode)
   );

   // Trace path has no back-pressure
   csr_gpr_shadow u_shadow (
      .rvvi              (rvvi),
      .reset             (reset),
      .ret               (ret.consumer),
      .trace_valid       (trace_valid),
      .trace_order       (trace_order),
      .trace_pc          (trace_pc),
      .trace_insn        (trace_insn),
      .trace_gpr_mask    (trace_gpr_mask),
      .trace_rd_wdata    (trace_rd_wdata),
      .trace_csr_slot    (trace_csr_slot),
      .trace_csr_value   (trace_csr_value),
      .trace_csr_changed (trace_csr_changed)
   );

   // Event path
   net_tracker u_tracker (
      .rvvi  (rvvi),
      .reset (reset),
      .irq   (irq),
      .ret   (ret.consumer),
      .ev    (ev.source)
   );

   net_event_queue u_queue (
      .rvvi         (rvvi),
      .reset        (reset),
      .ev           (ev.sink),
      .event_credit (event_credit),
      .event_valid  (event_valid),
      .event_id     (event_id),
      .event_value  (event_value)
   );

endmodule

// File: tb_rvvi_cases.svh
`ifndef TB_RVVI_CASES_SVH
`define TB_RVVI_CASES_SVH

localparam int NUM_CASES = 18;

case_t cases [NUM_CASES];

// Row layout
// name, order, trap, exc, intr, icause, nmip, dbg, dmode, rd, rd_wdata,
// csr_addr, csr_rdata, csr_wdata, csr_wmask, irq, credits,
// exp_valid, exp_mask, exp_rd, exp_slot, exp_csr, exp_changed, n_ev, ids, values
task automatic fill_cases();
   cases[0]  = '{"csr_write", 1, 0, 0, 0, 0, 0, 0, 0, 5, 32'h11111111, 12'h340, 0,
                 32'hAAAA5555, 32'hFFFFFFFF, 0, 0,
                 1, 32'h20, 32'h11111111, 3, 32'hAAAA5555, 1, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[1]  = '{"csr_partial", 2, 0, 0, 0, 0, 0, 0, 0, 0, 32'hDEADBEEF, 12'h340,
                 32'hAAAA5555, 32'h0000FFFF, 32'h00FF00FF, 0, 0,
                 1, 0, 0, 3, 32'hAA0055FF, 1, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[2]  = '{"csr_same", 3, 0, 0, 0, 0, 0, 0, 0, 31, 32'h12345678, 12'h340,
                 32'hAA0055FF, 0, 0, 0, 0,
                 1, 32'h80000000, 32'h12345678, 3, 32'hAA0055FF, 0, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[3]  = '{"csr_other", 4, 0, 0, 0, 0, 0, 0, 0, 1, 1, 12'h341, 0,
                 32'h80000004, 32'hFFFFFFFF, 0, 0,
                 1, 32'h2, 1, 4, 32'h80000004, 1, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[4]  = '{"repeat_order", 4, 0, 0, 0, 0, 0, 0, 0, 2, 32'hFFFF, 12'h300, 0,
                 32'h5, 32'hF, 0, 0, 0, 0, 0, 0, 0, 0, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[5]  = '{"untracked", 5, 0, 0, 0, 0, 0, 0, 0, 5, 32'h22222222, 12'hC00, 0,
                 32'h7, 32'hF, 0, 0,
                 1, 32'h20, 32'h22222222, 0, 0, 0, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[6]  = '{"nmi", 6, 0, 0, 1, 1024, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 2, '{net_nmi, net_nmi_cause, 0}, '{1, 1024, 0}};
   cases[7]  = '{"nmi_repeat", 7, 0, 0, 1, 1024, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[8]  = '{"nmi_clear", 8, 0, 0, 0, 0, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 1, '{net_nmi, 0, 0}, '{0, 0, 0}};
   cases[9]  = '{"fetch_fault", 9, 1, 48, 0, 0, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 1, '{net_ifault, 0, 0}, '{1, 0, 0}};
   cases[10] = '{"fault_clear", 10, 0, 0, 0, 0, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[11] = '{"halt_req", 11, 0, 0, 0, 0, 0, 3, 1, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[12] = '{"credit_back", 12, 0, 0, 0, 0, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 3,
                 1, 0, 0, 0, 0, 0, 3, '{net_ifault, net_haltreq, net_haltreq}, '{0, 1, 0}};
   cases[13] = '{"irq_rise", 13, 0, 0, 0, 0, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 32'h80, 4,
                 1, 0, 0, 0, 0, 0, 1, '{net_irq_1, 0, 0}, '{1, 0, 0}};
   cases[14] = '{"irq_fall", 14, 0, 0, 0, 0, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 1, '{net_irq_1, 0, 0}, '{0, 0, 0}};
   cases[15] = '{"quiet_inputs", 15, 0, 0, 0, 0, 0, 3, 0, 0, 0, 12'hC00, 0, 0, 0, 32'h1, 0,
                 1, 0, 0, 0, 0, 0, 0, '{0, 0, 0}, '{0, 0, 0}};
   cases[16] = '{"nmip_pending", 16, 0, 0, 0, 0, 1, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 1, '{net_nmi, 0, 0}, '{1, 0, 0}};
   cases[17] = '{"nmi_store", 17, 0, 0, 1, 1025, 0, 0, 0, 0, 0, 12'hC00, 0, 0, 0, 0, 0,
                 1, 0, 0, 0, 0, 0, 1, '{net_nmi_cause, 0, 0}, '{1025, 0, 0}};
endtask

`endif

// File: tb_rvvi_bridge.sv
`include "rvvi_defines.svh"

module tb_rvvi_bridge;
   import rvfi_trace_pkg::*;
   import rvvi_net_pkg::*;

   typedef struct packed {
      logic [95:0]       name;
      logic [63:0]       order;
      logic              trap;
      logic [5:0]        exc;
      logic              intr;
      logic [10:0]       icause;
      logic [1:0]        nmip;
      logic [2:0]        dbg;
      logic              dmode;
      logic [4:0]        rd;
      logic [31:0]       rd_wdata;
      logic [11:0]       csr_addr;
      logic [31:0]       csr_rdata;
      logic [31:0]       csr_wdata;
      logic [31:0]       csr_wmask;
      logic [31:0]       irq;
      logic [2:0]        credits;
      logic              exp_valid;
      logic [31:0]       exp_mask;
      logic [31:0]       exp_rd;
      logic [2:0]        exp_slot;
      logic [31:0]       exp_csr;
      logic              exp_changed;
      logic [1:0]        n_ev;
      logic [0:2][4:0]   ev_id;
      logic [0:2][31:0]  ev_val;
   } case_t;

   `include "tb_rvvi_cases.svh"

   logic        rvvi;
   logic        reset;
   logic        rvfi_valid;
   order_t      rvfi_order;
   xlen_t       rvfi_insn;
   xlen_t       rvfi_pc_rdata;
   xlen_t       rvfi_pc_wdata;
   logic        rvfi_trap;
   logic        rvfi_trap_exception;
   exc_cause_t  rvfi_exc_cause;
   logic        rvfi_intr;
   logic        rvfi_intr_interrupt;
   intr_cause_t rvfi_intr_cause;
   logic [1:0]  rvfi_nmip;
   logic [2:0]  rvfi_dbg;
   logic        rvfi_dbg_mode;
   reg_idx_t    rvfi_rd_addr;
   xlen_t       rvfi_rd_wdata;
   csr_addr_t   rvfi_csr_addr;
   xlen_t       rvfi_csr_rdata;
   xlen_t       rvfi_csr_wdata;
   xlen_t       rvfi_csr_wmask;
   logic [`IRQ_W-1:0] irq;
   logic        event_credit;
   logic        trace_valid;
   order_t      trace_order;
   xlen_t       trace_pc;
   xlen_t       trace_insn;
   gpr_mask_t   trace_gpr_mask;
   xlen_t       trace_rd_wdata;
   csr_slot_t   trace_csr_slot;
   xlen_t       trace_csr_value;
   logic        trace_csr_changed;
   logic        event_valid;
   net_id_t     event_id;
   net_value_t  event_value;

   int          row_errors;
   int          tests_run;
   int          tests_failed;
   int          credit_left;
   int          cycles;
   logic [4:0]  seen_id [$];
   logic [31:0] seen_val [$];

   rvvi_bridge dut (.*);

   initial begin
      rvvi = 1'b0;
      forever #2 rvvi = ~rvvi;
   end

   // Watchdog sized from the table length
   always @(posedge rvvi) begin
      cycles <= cycles + 1;
      if (cycles >= NUM_CASES * 10 + 100) begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // Every clock edge with event_valid high delivers one event
   always @(posedge rvvi) begin
      if (!reset && event_valid) begin
         seen_id.push_back(event_id);
         seen_val.push_back(event_value);
      end
   end

   task automatic update_credit();
      if (credit_left > 0) begin
         event_credit = 1'b1;
         credit_left--;
      end else begin
         event_credit = 1'b0;
      end
   endtask

   task automatic next_cycle();
      @(negedge rvvi);
      update_credit();
   endtask

   task automatic check_value(input string test, input string field,
                              input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act) else begin
         $display("error %s %s: expected %h, actual %h", test, field, exp, act);
         row_errors++;
      end
   endtask

   task automatic report_test(input string test);
      tests_run++;
      if (row_errors == 0) begin
         $display("test %s: ok", test);
      end else begin
         $display("test %s: failed with %0d errors", test, row_errors);
         tests_failed++;
      end
   endtask

   ////////////////////
   // One table row
   ////////////////////
   task automatic run_case(input case_t c);
      string nm;
      xlen_t exp_pc;
      int    waited;
      nm          = $sformatf("%0s", c.name);
      row_errors  = 0;
      credit_left = int'(c.credits);
      update_credit();
      rvfi_valid          = 1'b1;
      rvfi_order          = c.order;
      rvfi_pc_rdata       = $urandom;
      rvfi_pc_wdata       = $urandom;
      rvfi_insn           = $urandom;
      rvfi_trap           = c.trap;
      rvfi_trap_exception = c.trap;
      rvfi_exc_cause      = c.exc;
      rvfi_intr           = c.intr;
      rvfi_intr_interrupt = c.intr;
      rvfi_intr_cause     = c.icause;
      rvfi_nmip           = c.nmip;
      rvfi_dbg            = c.dbg;
      rvfi_dbg_mode       = c.dmode;
      rvfi_rd_addr        = c.rd;
      rvfi_rd_wdata       = c.rd_wdata;
      rvfi_csr_addr       = c.csr_addr;
      rvfi_csr_rdata      = c.csr_rdata;
      rvfi_csr_wdata      = c.csr_wdata;
      rvfi_csr_wmask      = c.csr_wmask;
      irq                 = c.irq;
      // A faulted fetch reports the handler address
      exp_pc = (c.trap && c.exc == 6'd48) ? rvfi_pc_wdata : rvfi_pc_rdata;
      next_cycle();
      rvfi_valid = 1'b0;
      next_cycle();
      check_value(nm, "trace_valid", 64'(c.exp_valid), 64'(trace_valid));
      if (c.exp_valid) begin
         check_value(nm, "trace_order", c.order, trace_order);
         check_value(nm, "trace_pc", 64'(exp_pc), 64'(trace_pc));
         check_value(nm, "trace_insn", 64'(rvfi_insn), 64'(trace_insn));
         check_value(nm, "trace_gpr_mask", 64'(c.exp_mask), 64'(trace_gpr_mask));
         check_value(nm, "trace_rd_wdata", 64'(c.exp_rd), 64'(trace_rd_wdata));
         check_value(nm, "trace_csr_slot", 64'(c.exp_slot), 64'(trace_csr_slot));
         check_value(nm, "trace_csr_value", 64'(c.exp_csr), 64'(trace_csr_value));
         check_value(nm, "trace_csr_changed", 64'(c.exp_changed), 64'(trace_csr_changed));
      end
      waited = 0;
      while (seen_id.size() < int'(c.n_ev) && waited < 12) begin
         next_cycle();
         waited++;
      end
      // Quiet cycles catch any extra event
      repeat (3) next_cycle();
      assert (seen_id.size() == int'(c.n_ev)) else begin
         $display("error %s event_count: expected %0d, actual %0d",
                  nm, c.n_ev, seen_id.size());
         row_errors++;
      end
      for (int i = 0; i < int'(c.n_ev) && i < seen_id.size(); i++) begin
         check_value(nm, "event_id", 64'(c.ev_id[i]), 64'(seen_id[i]));
         check_value(nm, "event_value", 64'(c.ev_val[i]), 64'(seen_val[i]));
      end
      seen_id.delete();
      seen_val.delete();
      report_test(nm);
   endtask

   initial begin
      void'($urandom(32'h9ac2));
      cycles              = 0;
      tests_run           = 0;
      tests_failed        = 0;
      credit_left         = 0;
      reset               = 1'b1;
      rvfi_valid          = 1'b0;
      rvfi_order          = '0;
      rvfi_insn           = '0;
      rvfi_pc_rdata       = '0;
      rvfi_pc_wdata       = '0;
      rvfi_trap           = 1'b0;
      rvfi_trap_exception = 1'b0;
      rvfi_exc_cause      = '0;
      rvfi_intr           = 1'b0;
      rvfi_intr_interrupt = 1'b0;
      rvfi_intr_cause     = '0;
      rvfi_nmip           = '0;
      rvfi_dbg            = '0;
      rvfi_dbg_mode       = 1'b0;
      rvfi_rd_addr        = '0;
      rvfi_rd_wdata       = '0;
      rvfi_csr_addr       = '0;
      rvfi_csr_rdata      = '0;
      rvfi_csr_wdata      = '0;
      rvfi_csr_wmask      = '0;
      irq                 = '0;
      event_credit        = 1'b0;
      fill_cases();
      repeat (8) @(posedge rvvi);
      @(negedge rvvi);
      reset = 1'b0;
      // Outputs idle right after reset
      row_errors = 0;
      check_value("reset", "trace_valid", 64'(0), 64'(trace_valid));
      check_value("reset", "event_valid", 64'(0), 64'(event_valid));
      report_test("reset");
      for (int k = 0; k < NUM_CASES; k++) begin
         run_case(cases[k]);
      end
      $display("tests %0d, passed %0d, failed %0d",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: build.f
+incdir+.
rvfi_trace_pkg.sv
rvvi_net_pkg.sv
retire_if.sv
net_event_if.sv
retire_decode.sv
csr_gpr_shadow.sv
net_tracker.sv
net_event_queue.sv
rvvi_bridge.sv
tb_rvvi_bridge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_rvvi_bridge
FILELIST  := build.f

SRCS := $(shell grep -v '^+' $(FILELIST)) rvvi_defines.svh tb_rvvi_cases.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir
